//--- rtl/core_pkg.sv
package core_pkg;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_lui,
        op_load,
        op_store,
        op_none
    } op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } f2d_t;

    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        logic [31:0] src1;
        logic [31:0] src2;     // rk value or immediate
        logic [31:0] st_data;  // rd value for st.w
        logic [4:0]  dest;
        logic        rf_we;
    } d2e_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;   // alu result or memory address
        logic [4:0]  dest;
        logic        rf_we;
        logic        is_load;
    } e2m_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] value;
        logic [4:0]  dest;
        logic        rf_we;
    } m2w_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic        load;     // value not ready until memory
        logic [4:0]  dest;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_we;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } trace_t;

endpackage

//--- rtl/if_stage.sv
`timescale 1ns/1ps
module if_stage #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ds_allowin,
    input  core_pkg::br_t  br,
    output logic           inst_sram_en,
    output logic [3:0]     inst_sram_we,
    output logic [31:0]    inst_sram_addr,
    output logic [31:0]    inst_sram_wdata,
    input  logic [31:0]    inst_sram_rdata,
    output logic           fs_to_ds_valid,
    output core_pkg::f2d_t fs_to_ds_bus
);
    logic        fetch_on;  // pre-IF may issue
    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_allowin;
    logic [31:0] next_pc;
    logic        buf_valid;
    logic [31:0] inst_buf;

    assign fs_allowin = !fs_valid || ds_allowin;
    assign next_pc    = br.taken ? br.target : fs_pc + 32'd4;

    assign inst_sram_en    = fetch_on && fs_allowin;
    assign inst_sram_we    = 4'b0;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = 32'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_on  <= 1'b0;
            fs_valid  <= 1'b0;
            fs_pc     <= reset_pc - 32'd4;  // first sequential pc is reset_pc
            buf_valid <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (fs_allowin) begin
                fs_valid  <= fetch_on;
                buf_valid <= 1'b0;
            end else if (fs_valid) begin
                buf_valid <= 1'b1;  // keep inst while decode stalls
            end
            if (inst_sram_en) begin
                fs_pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && !fs_allowin && !buf_valid) begin
            inst_buf <= inst_sram_rdata;
        end
    end

    assign fs_to_ds_valid    = fs_valid && !br.taken;  // slot behind taken branch
    assign fs_to_ds_bus.pc   = fs_pc;
    assign fs_to_ds_bus.inst = buf_valid ? inst_buf : inst_sram_rdata;

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps
module id_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fs_to_ds_valid,
    input  core_pkg::f2d_t fs_to_ds_bus,
    output logic           ds_allowin,
    output core_pkg::br_t  br,
    input  logic           es_allowin,
    output logic           ds_to_es_valid,
    output core_pkg::d2e_t ds_to_es_bus,
    input  core_pkg::fwd_t es_fwd,
    input  core_pkg::fwd_t ms_fwd,
    input  core_pkg::fwd_t ws_fwd
);
    logic           ds_valid;
    core_pkg::f2d_t ds_bus;
    logic           ds_ready_go;
    logic [31:0]    inst;
    logic [4:0]     rd;
    logic [4:0]     rj;
    logic [4:0]     rk;
    logic [4:0]     r2;  // second read port, rk or rd
    logic           inst_add;
    logic           inst_sub;
    logic           inst_slt;
    logic           inst_and;
    logic           inst_or;
    logic           inst_xor;
    logic           inst_addi;
    logic           inst_lu12i;
    logic           inst_ld;
    logic           inst_st;
    logic           inst_beq;
    logic           inst_bne;
    logic           inst_b;
    logic           is_3r;
    logic           use_rj;
    logic           use_r2;
    core_pkg::op_e  op;
    logic [31:0]    rf [32];
    logic [31:0]    rf_rdata1;
    logic [31:0]    rf_rdata2;
    logic [31:0]    src1_val;
    logic [31:0]    src2_val;
    logic [31:0]    imm12;
    logic [31:0]    imm20;
    logic [31:0]    br_offs;
    logic           rj_eq_rd;
    logic           load_use;

    function automatic logic fwd_hit(input core_pkg::fwd_t f, input logic [4:0] r);
        return f.valid && f.we && f.dest == r && r != 5'd0;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    assign inst = ds_bus.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign inst_add   = inst[31:15] == 17'h00020;
    assign inst_sub   = inst[31:15] == 17'h00022;
    assign inst_slt   = inst[31:15] == 17'h00024;
    assign inst_and   = inst[31:15] == 17'h00029;
    assign inst_or    = inst[31:15] == 17'h0002a;
    assign inst_xor   = inst[31:15] == 17'h0002b;
    assign inst_addi  = inst[31:22] == 10'h00a;
    assign inst_lu12i = inst[31:25] == 7'h0a;
    assign inst_ld    = inst[31:22] == 10'h0a2;
    assign inst_st    = inst[31:22] == 10'h0a6;
    assign inst_beq   = inst[31:26] == 6'h16;
    assign inst_bne   = inst[31:26] == 6'h17;
    assign inst_b     = inst[31:26] == 6'h14;

    assign is_3r  = inst_add || inst_sub || inst_slt || inst_and || inst_or || inst_xor;
    assign use_r2 = is_3r || inst_st || inst_beq || inst_bne;
    assign use_rj = use_r2 || inst_addi || inst_ld;
    assign r2     = is_3r ? rk : rd;

    assign op = (inst_add || inst_addi) ? core_pkg::op_add :
                inst_sub   ? core_pkg::op_sub :
                inst_slt   ? core_pkg::op_slt :
                inst_and   ? core_pkg::op_and :
                inst_or    ? core_pkg::op_or :
                inst_xor   ? core_pkg::op_xor :
                inst_lu12i ? core_pkg::op_lui :
                inst_ld    ? core_pkg::op_load :
                inst_st    ? core_pkg::op_store :
                             core_pkg::op_none;

    always_ff @(posedge clk) begin
        if (ws_fwd.valid && ws_fwd.we && ws_fwd.dest != 5'd0) begin
            rf[ws_fwd.dest] <= ws_fwd.value;
        end
    end

    assign rf_rdata1 = (rj == 5'd0) ? 32'd0 : rf[rj];
    assign rf_rdata2 = (r2 == 5'd0) ? 32'd0 : rf[r2];

    // nearest producer wins
    assign src1_val = fwd_hit(es_fwd, rj) ? es_fwd.value :
                      fwd_hit(ms_fwd, rj) ? ms_fwd.value :
                      fwd_hit(ws_fwd, rj) ? ws_fwd.value : rf_rdata1;
    assign src2_val = fwd_hit(es_fwd, r2) ? es_fwd.value :
                      fwd_hit(ms_fwd, r2) ? ms_fwd.value :
                      fwd_hit(ws_fwd, r2) ? ws_fwd.value : rf_rdata2;

    assign load_use = es_fwd.load && ((use_rj && fwd_hit(es_fwd, rj)) ||
                                      (use_r2 && fwd_hit(es_fwd, r2)));

    assign ds_ready_go    = !load_use;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign imm12   = {{20{inst[21]}}, inst[21:10]};
    assign imm20   = {inst[24:5], 12'b0};
    assign br_offs = inst_b ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                            : {{14{inst[25]}}, inst[25:10], 2'b0};
    assign rj_eq_rd = src1_val == src2_val;

    assign br.taken  = ds_valid && ds_ready_go &&
                       (inst_b || (inst_beq && rj_eq_rd) || (inst_bne && !rj_eq_rd));
    assign br.target = ds_bus.pc + br_offs;

    assign ds_to_es_bus.pc      = ds_bus.pc;
    assign ds_to_es_bus.op      = op;
    assign ds_to_es_bus.src1    = src1_val;
    assign ds_to_es_bus.src2    = is_3r ? src2_val : (inst_lu12i ? imm20 : imm12);
    assign ds_to_es_bus.st_data = src2_val;
    assign ds_to_es_bus.dest    = rd;
    assign ds_to_es_bus.rf_we   = is_3r || inst_addi || inst_lu12i || inst_ld;

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps
module ex_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ds_to_es_valid,
    input  core_pkg::d2e_t ds_to_es_bus,
    output logic           es_allowin,
    input  logic           ms_allowin,
    output logic           es_to_ms_valid,
    output core_pkg::e2m_t es_to_ms_bus,
    output core_pkg::fwd_t es_fwd,
    output logic           data_sram_en,
    output logic [3:0]     data_sram_we,
    output logic [31:0]    data_sram_addr,
    output logic [31:0]    data_sram_wdata
);
    logic           es_valid;
    core_pkg::d2e_t es_bus;
    logic [31:0]    alu_result;
    logic           is_load;
    logic           is_store;
    logic           es_go;  // leaves execute this cycle

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_bus <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (es_bus.op)
            core_pkg::op_sub:  alu_result = es_bus.src1 - es_bus.src2;
            core_pkg::op_and:  alu_result = es_bus.src1 & es_bus.src2;
            core_pkg::op_or:   alu_result = es_bus.src1 | es_bus.src2;
            core_pkg::op_xor:  alu_result = es_bus.src1 ^ es_bus.src2;
            core_pkg::op_slt:  alu_result = {31'b0, $signed(es_bus.src1) < $signed(es_bus.src2)};
            core_pkg::op_lui:  alu_result = es_bus.src2;
            core_pkg::op_none: alu_result = 32'b0;
            default:           alu_result = es_bus.src1 + es_bus.src2;  // add, ld/st address
        endcase
    end

    assign is_load  = es_bus.op == core_pkg::op_load;
    assign is_store = es_bus.op == core_pkg::op_store;
    assign es_go    = es_valid && ms_allowin;

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    assign data_sram_en    = es_go && (is_load || is_store);
    assign data_sram_we    = (es_go && is_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_bus.st_data;

    assign es_to_ms_bus.pc      = es_bus.pc;
    assign es_to_ms_bus.result  = alu_result;
    assign es_to_ms_bus.dest    = es_bus.dest;
    assign es_to_ms_bus.rf_we   = es_bus.rf_we;
    assign es_to_ms_bus.is_load = is_load;

    assign es_fwd.valid = es_valid;
    assign es_fwd.we    = es_bus.rf_we;
    assign es_fwd.load  = is_load;
    assign es_fwd.dest  = es_bus.dest;
    assign es_fwd.value = alu_result;

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
module mem_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           es_to_ms_valid,
    input  core_pkg::e2m_t es_to_ms_bus,
    output logic           ms_allowin,
    input  logic           ws_allowin,
    output logic           ms_to_ws_valid,
    output core_pkg::m2w_t ms_to_ws_bus,
    output core_pkg::fwd_t ms_fwd,
    input  logic [31:0]    data_sram_rdata
);
    logic           ms_valid;
    core_pkg::e2m_t ms_bus;
    logic [31:0]    final_value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    assign final_value    = ms_bus.is_load ? data_sram_rdata : ms_bus.result;
    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    assign ms_to_ws_bus.pc    = ms_bus.pc;
    assign ms_to_ws_bus.value = final_value;
    assign ms_to_ws_bus.dest  = ms_bus.dest;
    assign ms_to_ws_bus.rf_we = ms_bus.rf_we;

    assign ms_fwd.valid = ms_valid;
    assign ms_fwd.we    = ms_bus.rf_we;
    assign ms_fwd.load  = ms_bus.is_load;  // read data already here
    assign ms_fwd.dest  = ms_bus.dest;
    assign ms_fwd.value = final_value;

endmodule

//--- rtl/wb_stage.sv
`timescale 1ns/1ps
module wb_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ms_to_ws_valid,
    input  core_pkg::m2w_t ms_to_ws_bus,
    output logic           ws_allowin,
    output core_pkg::fwd_t ws_fwd,
    output logic [31:0]    debug_wb_pc,
    output logic [3:0]     debug_wb_rf_we,
    output logic [4:0]     debug_wb_rf_wnum,
    output logic [31:0]    debug_wb_rf_wdata
);
    logic           ws_valid;
    core_pkg::m2w_t ws_bus;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;  // always accepts
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign ws_allowin = 1'b1;  // last stage, never stalls

    assign ws_fwd.valid = ws_valid;
    assign ws_fwd.we    = ws_bus.rf_we;
    assign ws_fwd.load  = 1'b0;
    assign ws_fwd.dest  = ws_bus.dest;
    assign ws_fwd.value = ws_bus.value;

    assign debug_wb_pc       = ws_bus.pc;
    assign debug_wb_rf_we    = {4{ws_valid && ws_bus.rf_we && ws_bus.dest != 5'd0}};
    assign debug_wb_rf_wnum  = ws_bus.dest;
    assign debug_wb_rf_wdata = ws_bus.value;

endmodule

//--- rtl/mycpu_top.sv
`timescale 1ns/1ps
module mycpu_top #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    // inst sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // writeback trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic           ds_allowin;
    logic           es_allowin;
    logic           ms_allowin;
    logic           ws_allowin;
    logic           fs_to_ds_valid;
    logic           ds_to_es_valid;
    logic           es_to_ms_valid;
    logic           ms_to_ws_valid;
    core_pkg::f2d_t fs_to_ds_bus;
    core_pkg::d2e_t ds_to_es_bus;
    core_pkg::e2m_t es_to_ms_bus;
    core_pkg::m2w_t ms_to_ws_bus;
    core_pkg::fwd_t es_fwd;
    core_pkg::fwd_t ms_fwd;
    core_pkg::fwd_t ws_fwd;
    core_pkg::br_t  br;

    if_stage #(.reset_pc(reset_pc)) u_if (
        .clk(clk), .rst_n(rst_n), .ds_allowin(ds_allowin), .br(br),
        .inst_sram_en(inst_sram_en), .inst_sram_we(inst_sram_we),
        .inst_sram_addr(inst_sram_addr), .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus)
    );

    id_stage u_id (
        .clk(clk), .rst_n(rst_n),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus),
        .ds_allowin(ds_allowin), .br(br), .es_allowin(es_allowin),
        .ds_to_es_valid(ds_to_es_valid), .ds_to_es_bus(ds_to_es_bus),
        .es_fwd(es_fwd), .ms_fwd(ms_fwd), .ws_fwd(ws_fwd)
    );

    ex_stage u_ex (
        .clk(clk), .rst_n(rst_n),
        .ds_to_es_valid(ds_to_es_valid), .ds_to_es_bus(ds_to_es_bus),
        .es_allowin(es_allowin), .ms_allowin(ms_allowin),
        .es_to_ms_valid(es_to_ms_valid), .es_to_ms_bus(es_to_ms_bus), .es_fwd(es_fwd),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata)
    );

    mem_stage u_mem (
        .clk(clk), .rst_n(rst_n),
        .es_to_ms_valid(es_to_ms_valid), .es_to_ms_bus(es_to_ms_bus),
        .ms_allowin(ms_allowin), .ws_allowin(ws_allowin),
        .ms_to_ws_valid(ms_to_ws_valid), .ms_to_ws_bus(ms_to_ws_bus),
        .ms_fwd(ms_fwd), .data_sram_rdata(data_sram_rdata)
    );

    wb_stage u_wb (
        .clk(clk), .rst_n(rst_n),
        .ms_to_ws_valid(ms_to_ws_valid), .ms_to_ws_bus(ms_to_ws_bus),
        .ws_allowin(ws_allowin), .ws_fwd(ws_fwd),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

//--- bench/mycpu_properties.sv
`timescale 1ns/1ps
module mycpu_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           fs_to_ds_valid,
    input logic           ds_allowin,
    input core_pkg::f2d_t fs_to_ds_bus,
    input logic           ds_to_es_valid,
    input logic           es_to_ms_valid,
    input logic           ms_to_ws_valid,
    input logic           data_sram_en,
    input logic [3:0]     data_sram_we
);
    valids_low_after_reset: assert property (@(posedge clk) rst_n && !$past(rst_n) |->
        !fs_to_ds_valid && !ds_to_es_valid && !es_to_ms_valid && !ms_to_ws_valid)
        else $error("stage valid high in first cycle after reset");

    fetch_bus_held: assert property (@(posedge clk) disable iff (!rst_n)
        fs_to_ds_valid && !ds_allowin |=> $stable(fs_to_ds_bus))
        else $error("fetch bus changed while decode stalled");

    store_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_we != 4'h0 |-> data_sram_en)
        else $error("data sram write without enable");
endmodule

bind mycpu_top mycpu_properties props_inst (
    .clk(clk), .rst_n(rst_n),
    .fs_to_ds_valid(fs_to_ds_valid), .ds_allowin(ds_allowin), .fs_to_ds_bus(fs_to_ds_bus),
    .ds_to_es_valid(ds_to_es_valid),
    .es_to_ms_valid(es_to_ms_valid), .ms_to_ws_valid(ms_to_ws_valid),
    .data_sram_en(data_sram_en), .data_sram_we(data_sram_we)
);

//--- bench/tb_mycpu.sv
`timescale 1ns/1ps
module tb_mycpu;
    localparam logic [31:0] reset_pc = 32'h1c00_0000;
    localparam int num_tests = 5;
    localparam logic [16:0] add_w = 17'h00020;
    localparam logic [16:0] sub_w = 17'h00022;
    localparam logic [16:0] slt_w = 17'h00024;
    localparam logic [16:0] and_w = 17'h00029;
    localparam logic [16:0] or_w = 17'h0002a;
    localparam logic [16:0] xor_w = 17'h0002b;
    localparam logic [9:0] addi_w = 10'h00a;
    localparam logic [9:0] ld_w = 10'h0a2;
    localparam logic [9:0] st_w = 10'h0a6;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = 32'h0;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'h0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0]      imem [1024];
    logic [31:0]      dmem [1024];
    logic [31:0]      mdmem [1024];  // model copy of data memory
    logic [31:0]      mregs [32];
    logic [31:0]      prog [$];
    core_pkg::trace_t exp_q [$];
    core_pkg::trace_t got;
    integer           seed = 32'hf24c25b2;
    int               errors = 0;
    int               tests_run = 0;

    mycpu_top #(.reset_pc(reset_pc)) mycpu_top_inst (.*);

    always #10 clk = ~clk;

    // both srams, one-cycle read
    always @(posedge clk) begin
        if (inst_sram_en) begin
            if (inst_sram_we != 4'h0) begin
                imem[inst_sram_addr[11:2]] <= inst_sram_wdata;
            end
            inst_sram_rdata <= imem[inst_sram_addr[11:2]];
        end
        if (!rst_n) begin
            foreach (dmem[i]) dmem[i] <= 32'h0;
        end else if (data_sram_en) begin
            if (data_sram_we != 4'h0) begin
                dmem[data_sram_addr[11:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[11:2]];
        end
    end

    always @(negedge clk) begin
        if (rst_n && inst_sram_we != 4'h0) begin
            $display("CHECK FAILED inst_sram_we: got %h expected 0", inst_sram_we);
            errors++;
        end
        if (rst_n && debug_wb_rf_we != 4'h0) begin
            got = '{debug_wb_pc, debug_wb_rf_we, debug_wb_rf_wnum, debug_wb_rf_wdata};
            if (exp_q.size() == 0) begin
                $display("unexpected register write at pc %h", debug_wb_pc);
                errors++;
            end else begin
                compare_trace(got, exp_q.pop_front());
            end
        end
    end

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [4:0] rd, input logic [19:0] imm);
        return {7'h0a, imm, rd};
    endfunction

    // beq/bne compare rj with rd, offset in words
    function automatic logic [31:0] enc_br(input logic bne, input logic [4:0] rj,
                                           input logic [4:0] rd, input logic [15:0] offs);
        return {5'h0b, bne, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_b(input logic [25:0] offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($unsigned($random(seed)) % 9);
    endfunction

    task automatic compare_trace(input core_pkg::trace_t g, input core_pkg::trace_t e);
        if (g !== e) begin
            $display({"CHECK FAILED debug_wb trace: got pc %h we %h wnum %h wdata %h",
                      " expected pc %h we %h wnum %h wdata %h"},
                     g.pc, g.rf_we, g.rf_wnum, g.rf_wdata,
                     e.pc, e.rf_we, e.rf_wnum, e.rf_wdata);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] g, input logic [31:0] e);
        if (g !== e) begin
            $display("CHECK FAILED %s: got %h expected %h", name, g, e);
            errors++;
        end
    endtask

    // ISA reference model, runs until the closing self-branch
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next;
        logic [31:0] simm;
        logic        we;
        pc = reset_pc;
        mregs[0] = 32'h0;
        for (int step = 0; step < 500; step++) begin
            inst = imem[pc[11:2]];
            a    = mregs[inst[9:5]];
            simm = {{20{inst[21]}}, inst[21:10]};
            addr = a + simm;
            next = pc + 32'd4;
            we   = 1'b1;
            res  = 32'h0;
            case (1'b1)
                inst[31:15] == add_w: res = a + mregs[inst[14:10]];
                inst[31:15] == sub_w: res = a - mregs[inst[14:10]];
                inst[31:15] == and_w: res = a & mregs[inst[14:10]];
                inst[31:15] == or_w:  res = a | mregs[inst[14:10]];
                inst[31:15] == xor_w: res = a ^ mregs[inst[14:10]];
                inst[31:15] == slt_w: res = {31'h0, $signed(a) < $signed(mregs[inst[14:10]])};
                inst[31:22] == addi_w: res = addr;
                inst[31:25] == 7'h0a: res = {inst[24:5], 12'h0};
                inst[31:22] == ld_w: res = mdmem[addr[11:2]];
                default: we = 1'b0;
            endcase
            if (inst[31:22] == st_w) mdmem[addr[11:2]] = mregs[inst[4:0]];
            if (inst[31:27] == 5'h0b && ((a == mregs[inst[4:0]]) != inst[26])) begin
                next = pc + {{14{inst[25]}}, inst[25:10], 2'b0};
            end
            if (inst[31:26] == 6'h14) begin
                if (inst[25:0] == 26'h0) break;
                next = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            end
            if (we && inst[4:0] != 5'd0) begin
                mregs[inst[4:0]] = res;
                exp_q.push_back(core_pkg::trace_t'{pc, 4'hf, inst[4:0], res});
            end
            pc = next;
        end
    endtask

    task automatic run_program(input string name);
        int errors_before;
        int n;
        errors_before = errors;
        prog.push_back(enc_b(26'd0));  // park on self-branch
        @(posedge clk);
        #1 rst_n = 1'b0;
        foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        foreach (mdmem[i]) mdmem[i] = 32'h0;
        exp_q = {};
        run_model();
        @(negedge clk);  // reset is sampled at the next edge
        repeat (15) begin
            @(negedge clk);
            if (inst_sram_en) begin
                $display("CHECK FAILED inst_sram_en: got %h expected 0 during reset",
                         inst_sram_en);
                errors++;
            end
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!inst_sram_en && n < 4);
        if (!inst_sram_en) begin
            $display("instruction fetch did not start after reset");
            errors++;
        end
        compare_word("inst_sram_addr", inst_sram_addr, reset_pc);
        n = 0;
        while (exp_q.size() != 0 && n < 150) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("trace stopped with %0d register writes missing", exp_q.size());
            errors++;
        end
        repeat (10) @(posedge clk);
        foreach (dmem[i]) compare_word($sformatf("dmem[%0d]", i), dmem[i], mdmem[i]);
        tests_run++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic test_reset();
        prog = {};
        prog.push_back(enc_ri12(addi_w, 5'd1, 5'd0, 12'h001));
        prog.push_back(enc_ri12(addi_w, 5'd2, 5'd1, 12'h001));
        run_program("reset");
    endtask

    task automatic test_alu();
        prog = {};
        prog.push_back(enc_lu12i(5'd1, 20'habcde));
        prog.push_back(enc_ri12(addi_w, 5'd1, 5'd1, 12'h123));
        prog.push_back(enc_ri12(addi_w, 5'd2, 5'd0, 12'h7ff));
        prog.push_back(enc_3r(add_w, 5'd3, 5'd1, 5'd2));
        prog.push_back(enc_3r(sub_w, 5'd4, 5'd3, 5'd1));
        prog.push_back(enc_3r(and_w, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_3r(or_w, 5'd6, 5'd5, 5'd1));
        prog.push_back(enc_3r(xor_w, 5'd7, 5'd6, 5'd2));
        prog.push_back(enc_3r(slt_w, 5'd8, 5'd1, 5'd2));
        prog.push_back(enc_3r(slt_w, 5'd9, 5'd2, 5'd1));
        prog.push_back(enc_ri12(addi_w, 5'd0, 5'd1, 12'h001));  // r0 stays zero
        prog.push_back(enc_3r(add_w, 5'd10, 5'd0, 5'd2));
        run_program("alu");
    endtask

    task automatic test_mem();
        prog = {};
        prog.push_back(enc_ri12(addi_w, 5'd1, 5'd0, 12'h100));
        prog.push_back(enc_lu12i(5'd2, 20'h12345));
        prog.push_back(enc_ri12(addi_w, 5'd2, 5'd2, 12'h678));
        prog.push_back(enc_ri12(st_w, 5'd2, 5'd1, 12'h000));
        prog.push_back(enc_ri12(addi_w, 5'd3, 5'd0, 12'hff9));
        prog.push_back(enc_ri12(st_w, 5'd3, 5'd1, 12'h004));
        prog.push_back(enc_ri12(ld_w, 5'd4, 5'd1, 12'h000));
        prog.push_back(enc_3r(add_w, 5'd5, 5'd4, 5'd4));  // load-use
        prog.push_back(enc_ri12(ld_w, 5'd6, 5'd1, 12'h004));
        prog.push_back(enc_3r(sub_w, 5'd7, 5'd6, 5'd4));
        prog.push_back(enc_ri12(st_w, 5'd5, 5'd1, 12'h008));
        prog.push_back(enc_ri12(ld_w, 5'd8, 5'd1, 12'h008));
        prog.push_back(enc_ri12(st_w, 5'd8, 5'd1, 12'h00c));
        run_program("load_store");
    endtask

    task automatic test_branch();
        prog = {};
        prog.push_back(enc_ri12(addi_w, 5'd1, 5'd0, 12'h005));
        prog.push_back(enc_ri12(addi_w, 5'd2, 5'd0, 12'h005));
        prog.push_back(enc_br(1'b0, 5'd1, 5'd2, 16'd2));  // beq taken
        prog.push_back(enc_ri12(addi_w, 5'd3, 5'd0, 12'h111));
        prog.push_back(enc_br(1'b1, 5'd1, 5'd2, 16'd2));  // bne not taken
        prog.push_back(enc_ri12(addi_w, 5'd4, 5'd0, 12'h022));
        prog.push_back(enc_br(1'b1, 5'd1, 5'd4, 16'd2));
        prog.push_back(enc_ri12(addi_w, 5'd5, 5'd0, 12'h333));
        prog.push_back(enc_br(1'b0, 5'd1, 5'd4, 16'd2));
        prog.push_back(enc_b(26'd2));
        prog.push_back(enc_ri12(addi_w, 5'd6, 5'd0, 12'h044));
        prog.push_back(enc_ri12(addi_w, 5'd7, 5'd1, 12'h001));
        run_program("branch");
    endtask

    task automatic test_random();
        logic [16:0] ops [6];
        int          kind;
        ops  = '{add_w, sub_w, slt_w, and_w, or_w, xor_w};
        prog = {};
        for (int r = 1; r <= 8; r++) begin
            prog.push_back(enc_lu12i(5'(r), 20'($random(seed))));
            prog.push_back(enc_ri12(addi_w, 5'(r), 5'(r), 12'($random(seed))));
        end
        repeat (40) begin
            kind = $unsigned($random(seed)) % 8;
            if (kind < 6) begin
                prog.push_back(enc_3r(ops[kind], rand_reg(), rand_reg(), rand_reg()));
            end else if (kind == 6) begin
                prog.push_back(enc_ri12(addi_w, rand_reg(), rand_reg(), 12'($random(seed))));
            end else begin
                prog.push_back(enc_lu12i(rand_reg(), 20'($random(seed))));
            end
        end
        run_program("random");
    endtask

    initial begin
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_random();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #((16 + 200 * num_tests) * 20);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- filelist.f
rtl/core_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mycpu_top.sv
bench/mycpu_properties.sv
bench/tb_mycpu.sv

//--- Makefile
TOP = tb_mycpu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir
